// File: logic/divide_isa_pkg.sv
`default_nettype none

package divide_isa_pkg;

    // architectural widths
    localparam int xlen = 64;
    localparam int wlen = 32;

    typedef logic [xlen-1:0] xword_t;

    // funct codes of the M-extension divide group
    typedef enum logic [3:0] {
        op_div  = 4'd4,
        op_divu = 4'd5,
        op_rem  = 4'd6,
        op_remu = 4'd7
    } div_func_t;

    // word results are sign-extended from bit 31
    function automatic xword_t sext_word(input xword_t value);
        return {{(xlen - wlen){value[wlen-1]}}, value[wlen-1:0]};
    endfunction

    // word operands are zero- or sign-extended by signedness
    function automatic xword_t narrow_word(input xword_t value, input logic signed_op);
        xword_t result;
        if (signed_op) begin
            result = sext_word(value);
        end else begin
            result = {{(xlen - wlen){1'b0}}, value[wlen-1:0]};
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// File: logic/divide_core_pkg.sv
`default_nettype none

package divide_core_pkg;

    // one quotient bit per step, word ops included
    localparam int div_steps = 64;

    typedef logic [$clog2(div_steps + 1)-1:0] step_cnt_t;

    // operation as captured at start
    typedef struct packed {
        logic rem_op;
        logic signed_op;
        logic word_op;
        logic quot_neg;
        logic rem_neg;
    } div_op_t;

    // special cases, in order of precedence
    typedef enum logic [1:0] {
        st_none          = 2'd0,
        st_zero_divisor  = 2'd1,
        st_overflow      = 2'd2,
        st_zero_dividend = 2'd3
    } div_status_t;

endpackage

`default_nettype wire

// File: logic/divide_decode.sv
`default_nettype none

module divide_decode (
    input  divide_isa_pkg::xword_t       opr_a_i,
    input  divide_isa_pkg::xword_t       opr_b_i,
    input  divide_isa_pkg::div_func_t    div_func_i,
    input  logic                         word_op_i,
    output divide_core_pkg::div_op_t     op_o,
    output divide_isa_pkg::xword_t       mag_a_o,
    output divide_isa_pkg::xword_t       mag_b_o,
    output divide_core_pkg::div_status_t status_o,
    output divide_isa_pkg::xword_t       special_res_o
);

    logic                   signed_op;
    logic                   rem_op;
    logic                   a_neg;
    logic                   b_neg;
    logic                   zero_divisor;
    logic                   overflow;
    logic                   zero_dividend;
    divide_isa_pkg::xword_t a_nar;
    divide_isa_pkg::xword_t b_nar;
    divide_isa_pkg::xword_t min_val;
    divide_isa_pkg::xword_t raw_res;

    assign signed_op = (div_func_i == divide_isa_pkg::op_div) ||
                       (div_func_i == divide_isa_pkg::op_rem);
    assign rem_op    = (div_func_i == divide_isa_pkg::op_rem) ||
                       (div_func_i == divide_isa_pkg::op_remu);

    assign a_nar = word_op_i ? divide_isa_pkg::narrow_word(opr_a_i, signed_op) : opr_a_i;
    assign b_nar = word_op_i ? divide_isa_pkg::narrow_word(opr_b_i, signed_op) : opr_b_i;

    // narrowed values are already extended, so bit 63 is the sign
    assign a_neg = signed_op & a_nar[divide_isa_pkg::xlen-1];
    assign b_neg = signed_op & b_nar[divide_isa_pkg::xlen-1];

    assign mag_a_o = a_neg ? -a_nar : a_nar;
    assign mag_b_o = b_neg ? -b_nar : b_nar;

    // most negative value of the selected width
    assign min_val = word_op_i ?
        divide_isa_pkg::sext_word(divide_isa_pkg::xword_t'(1) << (divide_isa_pkg::wlen - 1)) :
        divide_isa_pkg::xword_t'(1) << (divide_isa_pkg::xlen - 1);

    assign zero_divisor  = (b_nar == '0);
    assign overflow      = signed_op && (a_nar == min_val) && (b_nar == '1);
    assign zero_dividend = (a_nar == '0);

    always_comb begin
        if (zero_divisor) begin
            status_o = divide_core_pkg::st_zero_divisor;
        end else if (overflow) begin
            status_o = divide_core_pkg::st_overflow;
        end else if (zero_dividend) begin
            status_o = divide_core_pkg::st_zero_dividend;
        end else begin
            status_o = divide_core_pkg::st_none;
        end
    end

    always_comb begin
        case (status_o)
            divide_core_pkg::st_zero_divisor: raw_res = rem_op ? a_nar : '1;
            divide_core_pkg::st_overflow:     raw_res = rem_op ? '0 : min_val;
            default:                          raw_res = '0;
        endcase
    end

    // REMUW by zero still returns a sign-extended word
    assign special_res_o = word_op_i ? divide_isa_pkg::sext_word(raw_res) : raw_res;

    always_comb begin
        op_o.rem_op    = rem_op;
        op_o.signed_op = signed_op;
        op_o.word_op   = word_op_i;
        op_o.quot_neg  = a_neg ^ b_neg;
        // remainder follows the dividend
        op_o.rem_neg   = a_neg;
    end

endmodule

`default_nettype wire

// File: logic/divide_iter.sv
`default_nettype none

module divide_iter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load_i,
    input  logic                   step_i,
    input  divide_isa_pkg::xword_t mag_a_i,
    input  divide_isa_pkg::xword_t mag_b_i,
    output divide_isa_pkg::xword_t quot_o,
    output divide_isa_pkg::xword_t rem_o
);

    divide_isa_pkg::xword_t          divisor_q;
    divide_isa_pkg::xword_t          rem_q;
    divide_isa_pkg::xword_t          quot_q;
    logic [divide_isa_pkg::xlen:0]   shifted;
    logic [divide_isa_pkg::xlen+1:0] diff;
    logic                            fits;

    // next dividend bit comes out of the top of the quotient register
    assign shifted = {rem_q, quot_q[divide_isa_pkg::xlen-1]};

    // trial subtraction, borrow in the top bit
    assign diff = {1'b0, shifted} - {2'b00, divisor_q};
    assign fits = ~diff[divide_isa_pkg::xlen+1];

    always_ff @(posedge clk) begin
        if (load_i) begin
            divisor_q <= mag_b_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rem_q  <= '0;
            quot_q <= '0;
        end else if (load_i) begin
            rem_q  <= '0;
            quot_q <= mag_a_i;
        end else if (step_i) begin
            // restore by keeping the shifted value
            rem_q  <= fits ? diff[divide_isa_pkg::xlen-1:0] :
                             shifted[divide_isa_pkg::xlen-1:0];
            quot_q <= {quot_q[divide_isa_pkg::xlen-2:0], fits};
        end
    end

    assign quot_o = quot_q;
    assign rem_o  = rem_q;

endmodule

`default_nettype wire

// File: logic/divide_ctrl.sv
`default_nettype none

module divide_ctrl (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         div_instr_i,
    input  logic                         flush_i,
    input  divide_core_pkg::div_op_t     op_i,
    input  divide_core_pkg::div_status_t status_i,
    output logic                         load_o,
    output logic                         step_o,
    output logic                         done_o,
    output logic                         special_o,
    output divide_core_pkg::div_op_t     op_o,
    output logic                         busy_o
);

    logic                       run_q;
    logic                       special_q;
    logic                       last_step;
    divide_core_pkg::step_cnt_t count_q;
    divide_core_pkg::div_op_t   op_q;

    assign load_o    = div_instr_i & ~flush_i & (status_i == divide_core_pkg::st_none);
    assign last_step = (count_q == divide_core_pkg::step_cnt_t'(divide_core_pkg::div_steps));
    assign step_o    = run_q & ~last_step;
    // a flush on the finishing edge still drops the result
    assign done_o    = run_q & last_step & ~flush_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            run_q     <= 1'b0;
            count_q   <= '0;
            special_q <= 1'b0;
        end else begin
            special_q <= div_instr_i & ~flush_i & (status_i != divide_core_pkg::st_none);
            if (flush_i) begin
                run_q   <= 1'b0;
                count_q <= '0;
            end else if (load_o) begin
                run_q   <= 1'b1;
                count_q <= '0;
            end else if (done_o) begin
                run_q   <= 1'b0;
            end else if (step_o) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // signs and kind held for the result stage
    always_ff @(posedge clk) begin
        if (load_o) begin
            op_q <= op_i;
        end
    end

    assign special_o = special_q;
    assign op_o      = op_q;
    assign busy_o    = run_q;

endmodule

`default_nettype wire

// File: logic/divide_result.sv
`default_nettype none

module divide_result (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     done_i,
    input  logic                     special_i,
    input  divide_core_pkg::div_op_t op_i,
    input  divide_isa_pkg::xword_t   quot_i,
    input  divide_isa_pkg::xword_t   rem_i,
    input  divide_isa_pkg::xword_t   special_res_i,
    output divide_isa_pkg::xword_t   div_res_o,
    output logic                     valid_res_o
);

    divide_isa_pkg::xword_t mag_sel;
    divide_isa_pkg::xword_t signed_res;
    divide_isa_pkg::xword_t norm_res;
    divide_isa_pkg::xword_t special_q;
    logic                   negate;

    assign mag_sel    = op_i.rem_op ? rem_i : quot_i;
    assign negate     = op_i.rem_op ? op_i.rem_neg : op_i.quot_neg;
    assign signed_res = negate ? -mag_sel : mag_sel;
    assign norm_res   = op_i.word_op ? divide_isa_pkg::sext_word(signed_res) : signed_res;

    // special result sampled at the strobe edge, before operands move on
    always_ff @(posedge clk) begin
        special_q <= special_res_i;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            div_res_o   <= '0;
            valid_res_o <= 1'b0;
        end else begin
            valid_res_o <= done_i | special_i;
            if (special_i) begin
                div_res_o <= special_q;
            end else if (done_i) begin
                div_res_o <= norm_res;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/divide.sv
`default_nettype none

module divide (
    input  logic                      clk,
    input  logic                      reset,
    input  divide_isa_pkg::xword_t    opr_a_i,
    input  divide_isa_pkg::xword_t    opr_b_i,
    input  logic                      div_instr_i,
    input  divide_isa_pkg::div_func_t div_func_i,
    input  logic                      word_op_i,
    input  logic                      flush_i,
    output divide_isa_pkg::xword_t    div_res_o,
    output logic                      valid_res_o,
    output logic                      div_busy_o
);

    divide_core_pkg::div_op_t     dec_op;
    divide_core_pkg::div_op_t     run_op;
    divide_core_pkg::div_status_t status;
    divide_isa_pkg::xword_t       mag_a;
    divide_isa_pkg::xword_t       mag_b;
    divide_isa_pkg::xword_t       special_res;
    divide_isa_pkg::xword_t       quot;
    divide_isa_pkg::xword_t       rem;
    logic                         load;
    logic                         step;
    logic                         done;
    logic                         special;

    divide_decode u_decode (
        .opr_a_i       (opr_a_i),
        .opr_b_i       (opr_b_i),
        .div_func_i    (div_func_i),
        .word_op_i     (word_op_i),
        .op_o          (dec_op),
        .mag_a_o       (mag_a),
        .mag_b_o       (mag_b),
        .status_o      (status),
        .special_res_o (special_res)
    );

    divide_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .div_instr_i (div_instr_i),
        .flush_i     (flush_i),
        .op_i        (dec_op),
        .status_i    (status),
        .load_o      (load),
        .step_o      (step),
        .done_o      (done),
        .special_o   (special),
        .op_o        (run_op),
        .busy_o      (div_busy_o)
    );

    divide_iter u_iter (
        .clk     (clk),
        .reset   (reset),
        .load_i  (load),
        .step_i  (step),
        .mag_a_i (mag_a),
        .mag_b_i (mag_b),
        .quot_o  (quot),
        .rem_o   (rem)
    );

    divide_result u_result (
        .clk           (clk),
        .reset         (reset),
        .done_i        (done),
        .special_i     (special),
        .op_i          (run_op),
        .quot_i        (quot),
        .rem_i         (rem),
        .special_res_i (special_res),
        .div_res_o     (div_res_o),
        .valid_res_o   (valid_res_o)
    );

endmodule

`default_nettype wire

// File: testbench/divide_assert.sv
`default_nettype none

module divide_assert (
    input logic clk,
    input logic reset,
    input logic div_instr_i,
    input logic flush_i,
    input logic valid_res_o,
    input logic div_busy_o
);

    // dispatch only while idle
    instr_when_idle: assert property (@(posedge clk) disable iff (reset)
        !(div_instr_i && div_busy_o))
        else $error("div_instr_i asserted while div_busy_o is high");

    valid_one_cycle: assert property (@(posedge clk) disable iff (reset)
        valid_res_o |=> !valid_res_o)
        else $error("valid_res_o held high for two cycles");

    flush_ends_run: assert property (@(posedge clk) disable iff (reset)
        flush_i |=> !div_busy_o)
        else $error("div_busy_o still high in the cycle after flush_i");

endmodule

bind divide divide_assert u_assert (
    .clk         (clk),
    .reset       (reset),
    .div_instr_i (div_instr_i),
    .flush_i     (flush_i),
    .valid_res_o (valid_res_o),
    .div_busy_o  (div_busy_o)
);

`default_nettype wire

// File: testbench/divide_model.svh
`ifndef DIVIDE_MODEL_SVH
`define DIVIDE_MODEL_SVH

// ops that finish without the division loop
function automatic logic resolves_early(
    input divide_isa_pkg::div_func_t func,
    input logic                      word,
    input dword_t                    a,
    input dword_t                    b
);
    logic sgn;
    sgn = (func == divide_isa_pkg::op_div) || (func == divide_isa_pkg::op_rem);
    if (word) begin
        return (b[31:0] == '0) || (a[31:0] == '0) ||
               (sgn && a[31:0] == 32'h8000_0000 && b[31:0] == '1);
    end
    return (b == '0) || (a == '0) || (sgn && a == {1'b1, 63'b0} && b == '1);
endfunction

// RISC-V M rules: truncating quotient, remainder keeps the dividend sign
function automatic dword_t expected_result(
    input divide_isa_pkg::div_func_t func,
    input logic                      word,
    input dword_t                    a,
    input dword_t                    b
);
    logic        sgn;
    logic        rem;
    logic [31:0] r32;
    dword_t      r64;
    sgn = (func == divide_isa_pkg::op_div) || (func == divide_isa_pkg::op_rem);
    rem = (func == divide_isa_pkg::op_rem) || (func == divide_isa_pkg::op_remu);
    if (word) begin
        if (b[31:0] == '0) begin
            r32 = rem ? a[31:0] : '1;
        end else if (sgn && a[31:0] == 32'h8000_0000 && b[31:0] == '1) begin
            r32 = rem ? '0 : a[31:0];
        end else if (sgn) begin
            r32 = rem ? $signed(a[31:0]) % $signed(b[31:0]) :
                        $signed(a[31:0]) / $signed(b[31:0]);
        end else begin
            r32 = rem ? a[31:0] % b[31:0] : a[31:0] / b[31:0];
        end
        r64 = {{32{r32[31]}}, r32};
    end else if (b == '0) begin
        r64 = rem ? a : '1;
    end else if (sgn && a == {1'b1, 63'b0} && b == '1) begin
        r64 = rem ? '0 : a;
    end else if (sgn) begin
        r64 = rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
    end else begin
        r64 = rem ? a % b : a / b;
    end
    return r64;
endfunction

`endif

// File: testbench/divide_tb.sv
`default_nettype none

module divide_tb;

    typedef logic [divide_isa_pkg::xlen-1:0] dword_t;

    // one operation as issued
    typedef struct packed {
        divide_isa_pkg::div_func_t func;
        logic                      word;
        dword_t                    a;
        dword_t                    b;
    } div_req_t;

    localparam int reset_cycles = 16;
    localparam int op_count     = 124;
    localparam int cycle_limit  = op_count * 70 + reset_cycles + 200;
    localparam int result_wait  = 80;
    localparam int mode_xlen    = 0;
    localparam int mode_word    = 1;
    localparam int mode_special = 2;
    localparam int mode_flush   = 3;
    localparam int mode_zero    = 4;
    localparam int mode_fixed   = 5;

    logic                      clk;
    logic                      reset;
    logic                      div_instr_i;
    logic                      word_op_i;
    logic                      flush_i;
    divide_isa_pkg::div_func_t div_func_i;
    dword_t                    opr_a_i;
    dword_t                    opr_b_i;
    dword_t                    div_res_o;
    logic                      valid_res_o;
    logic                      div_busy_o;
    logic [31:0]               lfsr_q;
    int                        cycle_q = 0;
    int                        checks = 0;
    int                        errors = 0;

    `include "divide_model.svh"

    divide dut0 (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_q <= cycle_q + 1;
        if (cycle_q >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic dword_t rand_bits(input int n);
        dword_t r;
        logic   fb;
        int     i;
        r = '0;
        for (i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[62:0], fb};
        end
        return r;
    endfunction

    function automatic div_req_t make_req(input int mode, input int i);
        div_req_t req;
        dword_t   r;
        r        = rand_bits(9);
        req.word = (mode == mode_word) || (mode >= mode_special && i[2]);
        req.func = divide_isa_pkg::div_func_t'({2'b01, r[1:0]});
        req.a    = rand_bits(64);
        req.b    = rand_bits(64) >> (req.word ? {1'b0, r[6:2]} : r[7:2]);
        if (r[8]) begin
            req.b = -req.b;
        end
        case (mode)
            mode_special: begin
                if (!i[0]) begin
                    // upper half stays random in word mode
                    req.b = req.word ? {req.b[63:32], 32'h0} : '0;
                end else begin
                    req.func = divide_isa_pkg::div_func_t'({2'b01, r[1], 1'b0});
                    req.a    = req.word ? {req.a[63:32], 32'h8000_0000} : {1'b1, 63'b0};
                    req.b    = req.word ? {req.b[63:32], 32'hffff_ffff} : '1;
                end
            end
            mode_zero: begin
                req.func = divide_isa_pkg::div_func_t'({2'b01, i[1:0]});
                req.a    = req.word ? {req.a[63:32], 32'h0} : '0;
                req.b    = req.b | 64'h1;
            end
            mode_fixed: begin
                req.func = divide_isa_pkg::div_func_t'({2'b01, i[1:0]});
                req.a    = 64'hffff_ffff_ffff_fc18;
                req.b    = 64'd7;
            end
            default: begin
                // keep random operands on the loop path
                if (resolves_early(req.func, req.word, req.a, req.b)) begin
                    req.a = req.a | 64'h10;
                    req.b = 64'd3;
                end
            end
        endcase
        return req;
    endfunction

    task automatic check_op(input div_req_t req, input int flush_at);
        dword_t exp_res;
        logic   early;
        logic   seen;
        logic   exp_busy;
        int     exp_edge;
        int     edge_n;
        exp_res  = expected_result(req.func, req.word, req.a, req.b);
        early    = resolves_early(req.func, req.word, req.a, req.b);
        exp_edge = early ? 1 : 65;
        seen     = 1'b0;
        edge_n   = 0;
        @(posedge clk);
        div_instr_i <= 1'b1;
        div_func_i  <= req.func;
        word_op_i   <= req.word;
        opr_a_i     <= req.a;
        opr_b_i     <= req.b;
        // edge 0 takes the strobe and then the operands change
        @(posedge clk);
        div_instr_i <= 1'b0;
        opr_a_i     <= ~req.a;
        opr_b_i     <= ~req.b;
        flush_i     <= (flush_at == 1);
        while (!seen && edge_n < result_wait) begin
            @(posedge clk);
            edge_n++;
            flush_i <= (flush_at > 0) && (edge_n + 1 == flush_at);
            @(negedge clk);
            exp_busy = !early && (edge_n <= 64) && (flush_at == 0 || edge_n < flush_at);
            seen     = valid_res_o;
            checks++;
            assert (div_busy_o == exp_busy) else begin
                $display("mismatch at %0t: div_busy_o got %b, expected %b",
                         $time, div_busy_o, exp_busy);
                errors++;
            end
            assert (!(seen && flush_at > 0)) else begin
                $display("error at %0t: a flushed operation still returned a result", $time);
                errors++;
            end
            if (seen && flush_at == 0) begin
                checks += 2;
                assert (edge_n == exp_edge) else begin
                    $display("mismatch at %0t: valid_res_o edge got %0d, expected %0d",
                             $time, edge_n, exp_edge);
                    errors++;
                end
                assert (div_res_o == exp_res) else begin
                    $display("mismatch at %0t: div_res_o got %h, expected %h",
                             $time, div_res_o, exp_res);
                    errors++;
                end
            end
        end
        if (flush_at == 0) begin
            assert (seen) else begin
                $display("error at %0t: no valid_res_o within %0d cycles", $time, result_wait);
                errors++;
            end
        end
    endtask

    task automatic run_batch(input string name, input int mode, input int count);
        div_req_t req;
        dword_t   r;
        int       errs_before;
        int       i;
        errs_before = errors;
        for (i = 0; i < count; i++) begin
            req = make_req(mode, i);
            if (mode == mode_flush) begin
                r = rand_bits(6);
                check_op(req, 1 + r[5:0]);
                req = make_req(mode, i);
            end
            check_op(req, 0);
        end
        $display("test %s: %0d ops, %0d errors", name, count, errors - errs_before);
    endtask

    initial begin
        reset       = 1'b1;
        div_instr_i = 1'b0;
        word_op_i   = 1'b0;
        flush_i     = 1'b0;
        div_func_i  = divide_isa_pkg::op_div;
        opr_a_i     = '0;
        opr_b_i     = '0;
        lfsr_q      = 32'h6ef3_b8d5;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        run_batch("div64", mode_xlen, 40);
        run_batch("word", mode_word, 40);
        run_batch("special", mode_special, 16);
        run_batch("latency", mode_fixed, 4);
        run_batch("flush", mode_flush, 8);
        run_batch("zero dividend", mode_zero, 8);
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: divide.f
+incdir+testbench
logic/divide_isa_pkg.sv
logic/divide_core_pkg.sv
logic/divide_decode.sv
logic/divide_iter.sv
logic/divide_ctrl.sv
logic/divide_result.sv
logic/divide.sv
testbench/divide_assert.sv
testbench/divide_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 --top-module divide_tb -f divide.f -o divide_sim

# the log decides pass or fail
./obj_dir/divide_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi
exit 1
